/* include/arb_cfg.svh */
//##############################
// Widths and block size shared by the arbiter RTL and testbench
// Include wherever a `ARB_ macro is needed
//##############################

`ifndef ARB_CFG_SVH
`define ARB_CFG_SVH

// Memory word address
`define ARB_MEM_ADDR_W 26

// Transfer length in words
`define ARB_COUNT_W 24

// Largest single memory command, and the width that holds it
`define ARB_BLOCK_WORDS 256
`define ARB_BLOCK_LEN_W 9

`endif

/* verilog/dma_chan_pkg.sv */
//##############################
// Types for DMA channel requests
// Import where channel indices, counts or directions are used
//##############################

`include "arb_cfg.svh"

package dma_chan_pkg;

  // Channel index inside one direction
  typedef logic chan_idx_t;

  // Transfer length in words
  typedef logic [`ARB_COUNT_W-1:0] word_count_t;

  // Ingress writes memory, egress reads it
  typedef enum logic {
    DIR_INGRESS = 1'b0,
    DIR_EGRESS  = 1'b1
  } dma_dir_e;

endpackage

/* verilog/mem_cmd_pkg.sv */
//##############################
// Types for memory block commands
// Import where bus addresses or block lengths are used
//##############################

`include "arb_cfg.svh"

package mem_cmd_pkg;

  // Word address on the memory side
  typedef logic [`ARB_MEM_ADDR_W-1:0] mem_addr_t;

  // Words carried by one command, up to `ARB_BLOCK_WORDS
  typedef logic [`ARB_BLOCK_LEN_W-1:0] block_len_t;

  // Largest block as a typed constant
  localparam block_len_t BLOCK_MAX = block_len_t'(`ARB_BLOCK_WORDS);

endpackage

/* verilog/dma_channel_arbiter.sv */
//##############################
// Round-robin choice between the two channels of one direction
//##############################

module dma_channel_arbiter (
  input  logic                    clk,
  input  logic                    rst,

  // Channel enables, bit 0 is channel 0
  input  logic [1:0]              i_enable,

  // Sequencer accepted the current grant
  input  logic                    i_take,

  output logic                    o_req_any,
  output dma_chan_pkg::chan_idx_t o_grant
);

  import dma_chan_pkg::*;

  // Channel that wins the next tie
  chan_idx_t prio_q;

  assign o_req_any = |i_enable;

  always_comb begin
    case (i_enable)
      2'b01:   o_grant = 1'b0;
      2'b10:   o_grant = 1'b1;
      // Tie or no request, follow the priority bit
      default: o_grant = prio_q;
    endcase
  end

  // Loser of this round gets the next tie
  always_ff @(posedge clk) begin
    if (rst) begin
      prio_q <= 1'b0;
    end else if (i_take) begin
      prio_q <= ~o_grant;
    end
  end

  // Sequencer only takes a grant from a direction that asked
  a_take_has_req : assert property (
    @(posedge clk) disable iff (rst)
    i_take |-> o_req_any
  ) else $error("take without request");

endmodule

/* verilog/transfer_sequencer.sv */
//##############################
// Picks a direction, splits the granted transfer into blocks
// and issues each block as one Wishbone classic command
//##############################

`include "arb_cfg.svh"

module transfer_sequencer (
  input  logic                        clk,
  input  logic                        rst,

  // From the two direction arbiters
  input  logic                        i_ing_req,
  input  logic                        i_egr_req,
  input  dma_chan_pkg::chan_idx_t     i_ing_grant,
  input  dma_chan_pkg::chan_idx_t     i_egr_grant,
  output logic                        o_ing_take,
  output logic                        o_egr_take,

  // Channel transfer descriptors
  input  mem_cmd_pkg::mem_addr_t      i_ing_addr [0:1],
  input  mem_cmd_pkg::mem_addr_t      i_egr_addr [0:1],
  input  dma_chan_pkg::word_count_t   i_ing_count [0:1],
  input  dma_chan_pkg::word_count_t   i_egr_count [0:1],
  output logic [1:0]                  o_ing_done,
  output logic [1:0]                  o_egr_done,

  // Wishbone master toward the memory controller
  output logic                        o_wb_cyc,
  output logic                        o_wb_stb,
  output logic                        o_wb_we,
  output mem_cmd_pkg::mem_addr_t      o_wb_adr,
  output mem_cmd_pkg::block_len_t     o_wb_dat,
  input  logic                        i_wb_ack
);

  import dma_chan_pkg::*;
  import mem_cmd_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SELECT,
    ST_ISSUE,
    ST_DONE
  } state_e;

  state_e      state_q;
  dma_dir_e    dir_prio_q;
  dma_dir_e    dir_q;
  dma_dir_e    dir_pick;
  chan_idx_t   grant_q;
  chan_idx_t   sel_grant;
  mem_addr_t   sel_addr;
  word_count_t sel_count;
  mem_addr_t   addr_q;
  word_count_t remain_q;
  block_len_t  blk_len;
  logic        cyc_q;
  logic        stb_q;
  logic        blk_ack;

  // Direction choice, same rule as the channel arbiters
  always_comb begin
    case ({i_egr_req, i_ing_req})
      2'b01:   dir_pick = DIR_INGRESS;
      2'b10:   dir_pick = DIR_EGRESS;
      default: dir_pick = dir_prio_q;
    endcase
  end

  assign sel_grant = (dir_pick == DIR_INGRESS) ? i_ing_grant : i_egr_grant;
  assign sel_addr  = (dir_pick == DIR_INGRESS) ? i_ing_addr[i_ing_grant]
                                               : i_egr_addr[i_egr_grant];
  assign sel_count = (dir_pick == DIR_INGRESS) ? i_ing_count[i_ing_grant]
                                               : i_egr_count[i_egr_grant];

  assign o_ing_take = (state_q == ST_SELECT) && (dir_pick == DIR_INGRESS);
  assign o_egr_take = (state_q == ST_SELECT) && (dir_pick == DIR_EGRESS);

  // Last block may be short
  assign blk_len = (remain_q > word_count_t'(`ARB_BLOCK_WORDS)) ? BLOCK_MAX
                                                                : block_len_t'(remain_q);

  assign blk_ack = cyc_q && stb_q && i_wb_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      dir_prio_q <= DIR_INGRESS;
      dir_q      <= DIR_INGRESS;
      grant_q    <= 1'b0;
      cyc_q      <= 1'b0;
      stb_q      <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (i_ing_req || i_egr_req) begin
            state_q <= ST_SELECT;
          end
        end
        ST_SELECT: begin
          dir_prio_q <= dma_dir_e'(~dir_pick);
          dir_q      <= dir_pick;
          grant_q    <= sel_grant;
          state_q    <= ST_ISSUE;
        end
        ST_ISSUE: begin
          if (!cyc_q) begin
            // Bus idle, start the next block or finish
            if (remain_q == '0) begin
              state_q <= ST_DONE;
            end else begin
              cyc_q <= 1'b1;
              stb_q <= 1'b1;
            end
          end else if (blk_ack) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
          end
        end
        ST_DONE: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Address and remaining words of the transfer in flight
  always_ff @(posedge clk) begin
    if (state_q == ST_SELECT) begin
      addr_q   <= sel_addr;
      remain_q <= sel_count;
    end else if (blk_ack) begin
      addr_q   <= addr_q + mem_addr_t'(blk_len);
      remain_q <= remain_q - word_count_t'(blk_len);
    end
  end

  assign o_wb_cyc = cyc_q;
  assign o_wb_stb = stb_q;
  assign o_wb_we  = (dir_q == DIR_INGRESS);
  assign o_wb_adr = addr_q;
  assign o_wb_dat = blk_len;

  assign o_ing_done = (state_q == ST_DONE && dir_q == DIR_INGRESS) ? (2'b01 << grant_q)
                                                                   : 2'b00;
  assign o_egr_done = (state_q == ST_DONE && dir_q == DIR_EGRESS) ? (2'b01 << grant_q)
                                                                  : 2'b00;

  // Command held unchanged while the controller stalls
  a_cmd_stable : assert property (
    @(posedge clk) disable iff (rst)
    (o_wb_stb && !i_wb_ack) |=> ($stable(o_wb_adr) && $stable(o_wb_dat))
  ) else $error("command changed before ack");

  a_stb_in_cyc : assert property (
    @(posedge clk) disable iff (rst)
    o_wb_stb |-> o_wb_cyc
  ) else $error("stb without cyc");

  a_done_pulse : assert property (
    @(posedge clk) disable iff (rst)
    (|{o_ing_done, o_egr_done}) |=> !(|{o_ing_done, o_egr_done})
  ) else $error("done longer than one cycle");

endmodule

/* verilog/ddr3_arbiter_top.sv */
//##############################
// Four DMA channels sharing one memory controller port
//##############################

module ddr3_arbiter_top (
  input  logic                      clk,
  input  logic                      rst,

  // Ingress channels, written to memory
  input  logic                      i_ing0_enable,
  input  mem_cmd_pkg::mem_addr_t    i_ing0_addr,
  input  dma_chan_pkg::word_count_t i_ing0_count,
  output logic                      o_ing0_done,
  input  logic                      i_ing1_enable,
  input  mem_cmd_pkg::mem_addr_t    i_ing1_addr,
  input  dma_chan_pkg::word_count_t i_ing1_count,
  output logic                      o_ing1_done,

  // Egress channels, read from memory
  input  logic                      i_egr0_enable,
  input  mem_cmd_pkg::mem_addr_t    i_egr0_addr,
  input  dma_chan_pkg::word_count_t i_egr0_count,
  output logic                      o_egr0_done,
  input  logic                      i_egr1_enable,
  input  mem_cmd_pkg::mem_addr_t    i_egr1_addr,
  input  dma_chan_pkg::word_count_t i_egr1_count,
  output logic                      o_egr1_done,

  // Wishbone master
  output logic                      o_wb_cyc,
  output logic                      o_wb_stb,
  output logic                      o_wb_we,
  output mem_cmd_pkg::mem_addr_t    o_wb_adr,
  output mem_cmd_pkg::block_len_t   o_wb_dat,
  input  logic                      i_wb_ack
);

  import dma_chan_pkg::*;
  import mem_cmd_pkg::*;

  logic        ing_req;
  logic        egr_req;
  logic        ing_take;
  logic        egr_take;
  chan_idx_t   ing_grant;
  chan_idx_t   egr_grant;
  logic [1:0]  ing_done;
  logic [1:0]  egr_done;
  mem_addr_t   ing_addr [0:1];
  mem_addr_t   egr_addr [0:1];
  word_count_t ing_count [0:1];
  word_count_t egr_count [0:1];

  // Index the channel descriptors by grant
  assign ing_addr[0]  = i_ing0_addr;
  assign ing_addr[1]  = i_ing1_addr;
  assign egr_addr[0]  = i_egr0_addr;
  assign egr_addr[1]  = i_egr1_addr;
  assign ing_count[0] = i_ing0_count;
  assign ing_count[1] = i_ing1_count;
  assign egr_count[0] = i_egr0_count;
  assign egr_count[1] = i_egr1_count;

  assign o_ing0_done = ing_done[0];
  assign o_ing1_done = ing_done[1];
  assign o_egr0_done = egr_done[0];
  assign o_egr1_done = egr_done[1];

  dma_channel_arbiter u_ing_arb (
    .clk       (clk),
    .rst       (rst),
    .i_enable  ({i_ing1_enable, i_ing0_enable}),
    .i_take    (ing_take),
    .o_req_any (ing_req),
    .o_grant   (ing_grant)
  );

  dma_channel_arbiter u_egr_arb (
    .clk       (clk),
    .rst       (rst),
    .i_enable  ({i_egr1_enable, i_egr0_enable}),
    .i_take    (egr_take),
    .o_req_any (egr_req),
    .o_grant   (egr_grant)
  );

  transfer_sequencer u_seq (
    .clk         (clk),
    .rst         (rst),
    .i_ing_req   (ing_req),
    .i_egr_req   (egr_req),
    .i_ing_grant (ing_grant),
    .i_egr_grant (egr_grant),
    .o_ing_take  (ing_take),
    .o_egr_take  (egr_take),
    .i_ing_addr  (ing_addr),
    .i_egr_addr  (egr_addr),
    .i_ing_count (ing_count),
    .i_egr_count (egr_count),
    .o_ing_done  (ing_done),
    .o_egr_done  (egr_done),
    .o_wb_cyc    (o_wb_cyc),
    .o_wb_stb    (o_wb_stb),
    .o_wb_we     (o_wb_we),
    .o_wb_adr    (o_wb_adr),
    .o_wb_dat    (o_wb_dat),
    .i_wb_ack    (i_wb_ack)
  );

endmodule

/* dv/tb_mem_responder.sv */
//##############################
// Wishbone slave model for the arbiter testbench
// Acks after a random delay and logs every command in cmd_q
//##############################

`include "arb_cfg.svh"

module tb_mem_responder (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_cyc,
  input  logic                    i_stb,
  input  logic                    i_we,
  input  mem_cmd_pkg::mem_addr_t  i_adr,
  input  mem_cmd_pkg::block_len_t i_dat,
  output logic                    o_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CMD_W = 1 + `ARB_MEM_ADDR_W + `ARB_BLOCK_LEN_W;

  // One entry per command, {we, address, length}
  logic [CMD_W-1:0] cmd_q [$];
  logic [31:0]      lfsr_q = 32'h1b2e56c6;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Ack delay of 0 to 7 cycles, one LFSR step per bit
  task automatic draw_delay(output logic [2:0] d);
    int i;
    d = '0;
    for (i = 0; i < 3; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      d = {d[1:0], lfsr_q[0]};
    end
  endtask

  initial begin : respond
    logic [2:0] delay;
    o_ack <= 1'b0;
    forever begin
      @(posedge clk);
      if (!rst && i_cyc && i_stb) begin
        cmd_q.push_back({i_we, i_adr, i_dat});
        draw_delay(delay);
        repeat (delay) @(posedge clk);
        o_ack <= 1'b1;
        @(posedge clk);
        o_ack <= 1'b0;
      end
    end
  end

endmodule

/* dv/tb_ddr3_arbiter.sv */
//##############################
// Testbench for ddr3_arbiter_top
// Checks block commands and done order against a reference model
//##############################

`include "arb_cfg.svh"

module tb_ddr3_arbiter;

  timeunit 1ns;
  timeprecision 1ps;

  import dma_chan_pkg::*;
  import mem_cmd_pkg::*;

  localparam int CMD_W       = 1 + `ARB_MEM_ADDR_W + `ARB_BLOCK_LEN_W;
  localparam int RAND_ROUNDS = 8;
  // Fixed tests, then up to four 10-bit counts per random round
  localparam int MAX_WORDS   = 769 + 600 + 100 + 3 * 484 + RAND_ROUNDS * 4 * 1023;
  localparam int WATCHDOG_CYCLES = MAX_WORDS * 10 + 5000;

  logic        clk;
  logic        rst;
  logic [3:0]  en;
  logic [3:0]  done;
  mem_addr_t   addr_in [4];
  word_count_t cnt_in [4];
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  mem_addr_t   wb_adr;
  block_len_t  wb_dat;
  logic        wb_ack;

  // Channel order 0 ing0, 1 ing1, 2 egr0, 3 egr1
  mem_addr_t   t_addr [4];
  word_count_t t_count [4];

  logic [CMD_W-1:0] exp_q [$];
  logic [1:0]       done_exp_q [$];
  logic [31:0]      lfsr_q = 32'h1b2e56c6;

  // Arbitration model state
  logic ing_prio;
  logic egr_prio;
  logic dir_prio;

  string test_name = "reset";
  int    test_errs = 0;
  int    total_errs = 0;
  int    tests_run = 0;
  int    tests_failed = 0;

  ddr3_arbiter_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .i_ing0_enable (en[0]),
    .i_ing0_addr   (addr_in[0]),
    .i_ing0_count  (cnt_in[0]),
    .o_ing0_done   (done[0]),
    .i_ing1_enable (en[1]),
    .i_ing1_addr   (addr_in[1]),
    .i_ing1_count  (cnt_in[1]),
    .o_ing1_done   (done[1]),
    .i_egr0_enable (en[2]),
    .i_egr0_addr   (addr_in[2]),
    .i_egr0_count  (cnt_in[2]),
    .o_egr0_done   (done[2]),
    .i_egr1_enable (en[3]),
    .i_egr1_addr   (addr_in[3]),
    .i_egr1_count  (cnt_in[3]),
    .o_egr1_done   (done[3]),
    .o_wb_cyc      (wb_cyc),
    .o_wb_stb      (wb_stb),
    .o_wb_we       (wb_we),
    .o_wb_adr      (wb_adr),
    .o_wb_dat      (wb_dat),
    .i_wb_ack      (wb_ack)
  );

  tb_mem_responder u_resp (
    .clk   (clk),
    .rst   (rst),
    .i_cyc (wb_cyc),
    .i_stb (wb_stb),
    .i_we  (wb_we),
    .i_adr (wb_adr),
    .i_dat (wb_dat),
    .o_ack (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Expected block commands of one transfer
  function automatic void expand_blocks(input logic we, input mem_addr_t addr,
                                        input word_count_t count);
    mem_addr_t   a;
    word_count_t left;
    block_len_t  len;
    a = addr;
    left = count;
    while (left != '0) begin
      if (left > word_count_t'(`ARB_BLOCK_WORDS)) begin
        len = block_len_t'(`ARB_BLOCK_WORDS);
      end else begin
        len = block_len_t'(left);
      end
      exp_q.push_back({we, a, len});
      a = a + mem_addr_t'(len);
      left = left - word_count_t'(len);
    end
  endfunction

  // Next channel served out of the pending set, round robin on both levels
  function automatic logic [1:0] pick_next(input logic [3:0] pend);
    logic       dir;
    logic       sel;
    logic [1:0] side;
    if (|pend[1:0] && |pend[3:2]) begin
      dir = dir_prio;
    end else begin
      dir = |pend[3:2];
    end
    dir_prio = ~dir;
    side = dir ? pend[3:2] : pend[1:0];
    if (side == 2'b11) begin
      sel = dir ? egr_prio : ing_prio;
    end else begin
      sel = side[1];
    end
    if (dir) begin
      egr_prio = ~sel;
    end else begin
      ing_prio = ~sel;
    end
    return {dir, sel};
  endfunction

  // Raise all channels of mask together, drop each on its done
  task automatic run_test(input string name, input logic [3:0] mask);
    logic [3:0] pend;
    logic [1:0] ch;
    logic [1:0] exp_ch;
    int         left;
    int         i;
    test_name = name;
    test_errs = 0;
    pend = mask;
    while (pend != '0) begin
      ch = pick_next(pend);
      done_exp_q.push_back(ch);
      expand_blocks(~ch[1], t_addr[ch], t_count[ch]);
      pend[ch] = 1'b0;
    end
    @(posedge clk);
    for (i = 0; i < 4; i++) begin
      ch = 2'(i);
      if (mask[ch]) begin
        addr_in[ch] <= t_addr[ch];
        cnt_in[ch]  <= t_count[ch];
        en[ch]      <= 1'b1;
      end
    end
    left = $countones(mask);
    while (left > 0) begin
      @(posedge clk);
      for (i = 0; i < 4; i++) begin
        ch = 2'(i);
        if (done[ch]) begin
          en[ch] <= 1'b0;
          left--;
          assert (done_exp_q.size() != 0) else begin
            $display("Test %s: unexpected done on channel %0d", name, ch);
            test_errs++;
          end
          if (done_exp_q.size() != 0) begin
            exp_ch = done_exp_q.pop_front();
            assert (ch == exp_ch) else begin
              $display("FAILED %s done: expected channel %0d, actual %0d", name, exp_ch, ch);
              test_errs++;
            end
          end
        end
      end
    end
    repeat (4) @(posedge clk);
    assert (exp_q.size() == 0) else begin
      $display("Test %s: %0d expected commands were never issued", name, exp_q.size());
      test_errs++;
    end
    exp_q.delete();
    tests_run++;
    total_errs += test_errs;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("Test %s: %s, %0d errors", name, (test_errs == 0) ? "ok" : "wrong", test_errs);
  endtask

  // Every logged command against the head of the expected list
  initial begin : compare_cmds
    logic [CMD_W-1:0] act;
    logic [CMD_W-1:0] exp;
    forever begin
      @(posedge clk);
      while (u_resp.cmd_q.size() != 0) begin
        act = u_resp.cmd_q.pop_front();
        assert (exp_q.size() != 0) else begin
          $display("Test %s: command %h issued when none was expected", test_name, act);
          test_errs++;
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          assert (act == exp) else begin
            $display("FAILED %s: expected %h, actual %h", test_name, exp, act);
            test_errs++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, a transfer never completed", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] v;
    logic [3:0]  mask;
    logic [1:0]  ch;
    int          i;
    int          r;
    ing_prio = 1'b0;
    egr_prio = 1'b0;
    dir_prio = 1'b0;
    rst <= 1'b1;
    en  <= '0;
    for (i = 0; i < 4; i++) begin
      addr_in[i] <= '0;
      cnt_in[i]  <= '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // Tie straight after reset goes to channel 0
    t_addr[0] = 26'h0000400;
    t_count[0] = 257;
    t_addr[1] = 26'h0008000;
    t_count[1] = 512;
    run_test("ing_pair_after_reset", 4'b0011);

    t_addr[0] = 26'h0000100;
    t_count[0] = 600;
    run_test("ing0_600", 4'b0001);

    t_addr[3] = 26'h0020000;
    t_count[3] = 100;
    run_test("egr1_100", 4'b1000);

    // Two ingress and one egress, so ties between directions take turns
    t_addr[0] = 26'h0100000;
    t_count[0] = 120;
    t_addr[1] = 26'h0180000;
    t_count[1] = 64;
    t_addr[2] = 26'h0200000;
    t_count[2] = 300;
    for (r = 0; r < 3; r++) begin
      run_test($sformatf("ing_egr_round_%0d", r), 4'b0111);
    end

    for (r = 0; r < RAND_ROUNDS; r++) begin
      draw_bits(4, v);
      mask = v[3:0];
      if (mask == '0) begin
        mask = 4'b0010;
      end
      for (i = 0; i < 4; i++) begin
        ch = 2'(i);
        draw_bits(26, v);
        t_addr[ch] = mem_addr_t'(v[25:0]);
        // About one count in four is zero
        draw_bits(2, v);
        if (v[1:0] == 2'b00) begin
          t_count[ch] = '0;
        end else begin
          draw_bits(10, v);
          t_count[ch] = word_count_t'(v[9:0]);
        end
      end
      run_test($sformatf("random_%0d", r), mask);
    end

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
verilog/dma_chan_pkg.sv
verilog/mem_cmd_pkg.sv
verilog/dma_channel_arbiter.sv
verilog/transfer_sequencer.sv
verilog/ddr3_arbiter_top.sv
dv/tb_mem_responder.sv
dv/tb_ddr3_arbiter.sv

/* run_sim.sh */
#!/bin/sh
# Build the DMA arbiter testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_ddr3_arbiter -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
